//--- design/guess_pkg.sv
package guess_pkg;

    // ------------------------------------------------------------------
    // Tick divisors, in clocks (scaled down for simulation)
    // ------------------------------------------------------------------
    localparam int sample_div = 2;     // Debounce sample tick
    localparam int logic_div  = 16;    // Game logic tick
    localparam int led_div    = 80;    // Win LED flow tick
    localparam int second_div = 400;   // Countdown tick and divider wrap

    // ------------------------------------------------------------------
    // Game constants
    // ------------------------------------------------------------------
    localparam int start_seconds    = 99;
    localparam int secret_limit     = 100;   // Secret drawn from 0 to 99
    localparam int hint_seconds     = 2;     // High/low hint hold
    localparam int debounce_samples = 2;     // Differing samples before a level change
    localparam int queue_depth      = 4;
    localparam int btn_count        = 4;

    // Counter widths derived from the constants above
    localparam int div_cnt_w  = $clog2(second_div);
    localparam int deb_cnt_w  = $clog2(debounce_samples + 1);
    localparam int qptr_w     = $clog2(queue_depth);
    localparam int hint_cnt_w = $clog2(hint_seconds + 1);

    // Button index, lowest code wins on simultaneous presses
    typedef enum logic [1:0] {
        btn_toggle  = 2'd0,   // Swap edited digit
        btn_up      = 2'd1,
        btn_down    = 2'd2,
        btn_confirm = 2'd3    // Start, confirm, play again
    } button_code_t;

    typedef enum logic [2:0] {
        phase_idle, phase_load, phase_entry, phase_check,
        phase_high, phase_low, phase_win, phase_lose
    } phase_t;

    // LED patterns per phase
    localparam logic [15:0] led_idle       = 16'h0001;
    localparam logic [15:0] led_load       = 16'h0002;
    localparam logic [15:0] led_entry      = 16'h0004;
    localparam logic [15:0] led_check      = 16'h0008;
    localparam logic [15:0] led_high       = 16'h0100;
    localparam logic [15:0] led_low        = 16'h0200;
    localparam logic [15:0] led_lose       = 16'hAAAA;   // Every other LED
    localparam logic [15:0] led_flow_start = 16'h0001;   // Win rotation start

    typedef logic [3:0] digit_t;     // Decimal digit 0..9
    typedef logic [6:0] seconds_t;   // Countdown 0..99

    localparam logic [15:0] lfsr_seed = 16'hACE1;   // Also the reseed value

endpackage

//--- design/tick_divider.sv
`timescale 1ns/1ps

module tick_divider import guess_pkg::*; (
    input  logic IN_CLK,
    input  logic ENABLE,
    output logic sample_tick,
    output logic logic_tick,
    output logic led_tick,
    output logic second_tick
);

    logic [div_cnt_w-1:0] div_cnt;   // Wraps once per second tick

    // ------------------------------------------------------------------
    // Shared wrapping counter
    // ------------------------------------------------------------------
    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            div_cnt <= '0;
        end else if (div_cnt == div_cnt_w'(second_div - 1)) begin
            div_cnt <= '0;   // End of second period
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // All divisors split second_div evenly, so the wrap keeps them in phase
    // Each enable fires on the last count of its own period
    assign sample_tick = (32'(div_cnt) % sample_div) == sample_div - 1;
    assign logic_tick  = (32'(div_cnt) % logic_div) == logic_div - 1;
    assign led_tick    = (32'(div_cnt) % led_div) == led_div - 1;
    assign second_tick = div_cnt == div_cnt_w'(second_div - 1);   // Same as wrap

endmodule

//--- design/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner import guess_pkg::*; (
    input  logic                 IN_CLK,
    input  logic                 ENABLE,
    input  logic                 sample_tick,
    input  logic [btn_count-1:0] buttons,      // Raw, active high
    output logic                 press_valid,  // One-cycle strobe
    output button_code_t         press_code
);

    logic [btn_count-1:0] btn_reg;      // Raw levels, registered once
    logic [btn_count-1:0] btn_stable;   // Debounced level
    logic [btn_count-1:0] btn_prev;     // Stable level one sample back
    logic [btn_count-1:0] btn_rise;
    logic [deb_cnt_w-1:0] deb_cnt [btn_count];
    button_code_t         first_code;

    assign btn_rise = btn_stable & ~btn_prev;

    // Lowest index wins, the rest of a simultaneous group is dropped
    always_comb begin
        first_code = btn_toggle;
        for (int i = btn_count - 1; i >= 0; i--) begin
            if (btn_rise[i]) begin
                first_code = button_code_t'(i[1:0]);
            end
        end
    end

    // ------------------------------------------------------------------
    // Debounce and press detection
    // ------------------------------------------------------------------
    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            btn_reg     <= '0;
            btn_stable  <= '0;
            btn_prev    <= '0;
            press_valid <= 1'b0;
            press_code  <= btn_toggle;
            for (int i = 0; i < btn_count; i++) begin
                deb_cnt[i] <= '0;
            end
        end else begin
            btn_reg     <= buttons;   // Every clock
            press_valid <= 1'b0;      // Default, strobe only
            if (sample_tick) begin
                for (int i = 0; i < btn_count; i++) begin
                    if (btn_reg[i] != btn_stable[i]) begin
                        if (deb_cnt[i] == deb_cnt_w'(debounce_samples - 1)) begin
                            btn_stable[i] <= btn_reg[i];   // Level accepted
                            deb_cnt[i]    <= '0;
                        end else begin
                            deb_cnt[i] <= deb_cnt[i] + 1'b1;
                        end
                    end else begin
                        deb_cnt[i] <= '0;   // Bounce back, start over
                    end
                end
                btn_prev <= btn_stable;
                // Rise seen one sample after the stable level moved
                if (|btn_rise) begin
                    press_valid <= 1'b1;
                    press_code  <= first_code;
                end
            end
        end
    end

endmodule

//--- design/press_queue.sv
`timescale 1ns/1ps

module press_queue import guess_pkg::*; (
    input  logic         IN_CLK,
    input  logic         ENABLE,
    input  logic         push,
    input  button_code_t push_code,
    input  logic         pop,          // Engine only pops when not empty
    output button_code_t head_code,
    output logic         queue_empty
);

    button_code_t      mem [queue_depth];
    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [qptr_w:0]   count;          // 0..queue_depth
    logic              full;
    logic              do_push;

    assign full        = count == (qptr_w + 1)'(queue_depth);
    assign do_push     = push && !full;   // Press lost when full
    assign queue_empty = count == '0;
    assign head_code   = mem[rd_ptr];

    // ------------------------------------------------------------------
    // Circular buffer
    // ------------------------------------------------------------------
    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            for (int i = 0; i < queue_depth; i++) begin
                mem[i] <= btn_toggle;
            end
        end else begin
            if (do_push) begin
                mem[wr_ptr] <= push_code;
                wr_ptr      <= (wr_ptr == qptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == qptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/game_engine.sv
`timescale 1ns/1ps

module game_engine import guess_pkg::*; (
    input  logic         IN_CLK,
    input  logic         ENABLE,
    input  logic         logic_tick,
    input  logic         second_tick,
    input  logic         led_tick,
    input  logic         queue_empty,
    input  button_code_t head_code,
    output logic         pop,
    output phase_t       phase,
    output logic [15:0]  led,
    output digit_t       guess_tens,
    output digit_t       guess_units,
    output logic         edit_tens,    // High while the tens digit is edited
    output seconds_t     time_left
);

    logic [15:0]           lfsr;
    logic [6:0]            secret;
    logic [6:0]            guess_value;
    logic [hint_cnt_w-1:0] hint_cnt;     // Second ticks spent on a hint
    logic                  sec_pend;
    logic                  led_pend;
    logic                  sec_hit;
    logic                  led_hit;
    logic                  timed_phase;  // Countdown runs here
    logic                  press_toggle;
    logic                  press_up;
    logic                  press_down;
    logic                  press_confirm;

    // Wrap-around step of one decimal digit
    function automatic digit_t digit_step(input digit_t d, input logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    // One press per logic tick
    assign pop           = logic_tick && !queue_empty;
    assign press_toggle  = pop && head_code == btn_toggle;
    assign press_up      = pop && head_code == btn_up;
    assign press_down    = pop && head_code == btn_down;
    assign press_confirm = pop && head_code == btn_confirm;

    assign guess_value = 7'(guess_tens) * 7'd10 + 7'(guess_units);
    assign timed_phase = phase inside {phase_entry, phase_check, phase_high, phase_low};

    // A tick landing on the logic tick itself counts right away
    assign sec_hit = sec_pend || second_tick;
    assign led_hit = led_pend || led_tick;

    // ------------------------------------------------------------------
    // Free-running LFSR and pending tick flags
    // ------------------------------------------------------------------
    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            lfsr <= lfsr_seed;
        end else if (lfsr == '0) begin
            lfsr <= lfsr_seed;   // Stuck state, reseed
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            sec_pend <= 1'b0;
            led_pend <= 1'b0;
        end else if (logic_tick) begin
            sec_pend <= 1'b0;   // Consumed
            led_pend <= 1'b0;
        end else begin
            if (second_tick) sec_pend <= 1'b1;
            if (led_tick)    led_pend <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Game FSM, advances on logic ticks only
    // ------------------------------------------------------------------
    always_ff @(posedge IN_CLK or negedge ENABLE) begin
        if (!ENABLE) begin
            phase       <= phase_idle;
            led         <= '0;
            guess_tens  <= '0;
            guess_units <= '0;
            edit_tens   <= 1'b1;
            time_left   <= seconds_t'(start_seconds);
            secret      <= '0;
            hint_cnt    <= '0;
        end else if (logic_tick) begin
            if (timed_phase && time_left == '0) begin
                phase <= phase_lose;   // Timeout beats everything
                led   <= led_lose;
            end else begin
                if (timed_phase && sec_hit) begin
                    time_left <= time_left - 7'd1;
                end
                case (phase)
                    phase_idle: begin
                        led         <= led_idle;
                        guess_tens  <= '0;
                        guess_units <= '0;
                        edit_tens   <= 1'b1;
                        time_left   <= seconds_t'(start_seconds);
                        if (press_confirm) phase <= phase_load;
                    end
                    phase_load: begin
                        led <= led_load;
                        // Retry until the low bits land in range
                        if (lfsr[6:0] < 7'(secret_limit)) begin
                            secret <= lfsr[6:0];
                            phase  <= phase_entry;
                        end
                    end
                    phase_entry: begin
                        led <= led_entry;
                        if (press_toggle) edit_tens <= !edit_tens;
                        if (press_up || press_down) begin
                            if (edit_tens) begin
                                guess_tens <= digit_step(guess_tens, press_up);
                            end else begin
                                guess_units <= digit_step(guess_units, press_up);
                            end
                        end
                        if (press_confirm) phase <= phase_check;
                    end
                    phase_check: begin
                        led      <= led_check;
                        hint_cnt <= '0;
                        if (guess_value == secret) begin
                            phase <= phase_win;
                            led   <= led_flow_start;
                        end else if (guess_value > secret) begin
                            phase <= phase_high;
                            led   <= led_high;
                        end else begin
                            phase <= phase_low;
                            led   <= led_low;
                        end
                    end
                    phase_high, phase_low: begin
                        if (sec_hit) begin
                            if (hint_cnt == hint_cnt_w'(hint_seconds - 1)) begin
                                guess_tens  <= '0;   // Fresh guess
                                guess_units <= '0;
                                edit_tens   <= 1'b1;
                                phase       <= phase_entry;
                            end else begin
                                hint_cnt <= hint_cnt + 1'b1;
                            end
                        end
                    end
                    phase_win: begin
                        if (led_hit) led <= {led[14:0], led[15]};   // Rotate left
                        if (press_confirm) phase <= phase_idle;
                    end
                    phase_lose: begin
                        led <= led_lose;
                        if (press_confirm) phase <= phase_idle;
                    end
                    default: phase <= phase_idle;
                endcase
            end
        end
    end

endmodule

//--- design/guess_number_top.sv
`timescale 1ns/1ps

module guess_number_top import guess_pkg::*; (
    input  logic                 IN_CLK,
    input  logic                 ENABLE,
    input  logic [btn_count-1:0] buttons,
    output phase_t               phase,
    output logic [15:0]          led,
    output digit_t               guess_tens,
    output digit_t               guess_units,
    output logic                 edit_tens,
    output seconds_t             time_left
);

    logic         sample_tick;
    logic         logic_tick;
    logic         led_tick;
    logic         second_tick;
    logic         press_valid;
    button_code_t press_code;
    logic         pop;
    button_code_t head_code;
    logic         queue_empty;

    // ------------------------------------------------------------------
    // Enables, buttons, press buffer, game
    // ------------------------------------------------------------------
    tick_divider u_tick_divider (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .sample_tick (sample_tick),
        .logic_tick  (logic_tick),
        .led_tick    (led_tick),
        .second_tick (second_tick)
    );

    button_conditioner u_button_conditioner (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .sample_tick (sample_tick),
        .buttons     (buttons),
        .press_valid (press_valid),
        .press_code  (press_code)
    );

    // Holds presses until the slower logic tick
    press_queue u_press_queue (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .push        (press_valid),
        .push_code   (press_code),
        .pop         (pop),
        .head_code   (head_code),
        .queue_empty (queue_empty)
    );

    game_engine u_game_engine (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .logic_tick  (logic_tick),
        .second_tick (second_tick),
        .led_tick    (led_tick),
        .queue_empty (queue_empty),
        .head_code   (head_code),
        .pop         (pop),
        .phase       (phase),
        .led         (led),
        .guess_tens  (guess_tens),
        .guess_units (guess_units),
        .edit_tens   (edit_tens),
        .time_left   (time_left)
    );

endmodule

//--- tests/guess_number_checker.sv
`timescale 1ns/1ps

module guess_number_checker import guess_pkg::*; (
    input logic            IN_CLK,
    input logic            ENABLE,
    input logic            pop,
    input logic            queue_empty,
    input logic [qptr_w:0] count          // Occupancy inside the queue
);

    // ------------------------------------------------------------------
    // Press queue rules
    // ------------------------------------------------------------------
    // Engine pops only while a press waits
    no_pop_when_empty: assert property (@(posedge IN_CLK) disable iff (!ENABLE)
        pop |-> !queue_empty)
        else $error("pop while the press queue is empty");

    count_in_range: assert property (@(posedge IN_CLK) disable iff (!ENABLE)
        count <= (qptr_w + 1)'(queue_depth))   // Full drops, never overflows
        else $error("press queue count above its depth");

    // First edge out of reset sees nothing queued
    empty_after_reset: assert property (@(posedge IN_CLK)
        $rose(ENABLE) |-> queue_empty)
        else $error("press queue not empty after reset");

endmodule

//--- include/guess_tb_tasks.svh
`ifndef guess_tb_tasks_svh
`define guess_tb_tasks_svh

// ----------------------------------------------------------------------
// Reporting, polling and button helpers
// ----------------------------------------------------------------------
task automatic abort_run(input string reason);
    $display("Testbench failed");
    $fatal(1, "%s", reason);
endtask

task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
        abort_run($sformatf("%s holds the wrong value", name));
    end
endtask

// Current value of a named DUT output
function automatic int output_value(input string name);
    case (name)
        "phase":       return int'(phase);
        "led":         return int'(led);
        "guess_tens":  return int'(guess_tens);
        "guess_units": return int'(guess_units);
        "edit_tens":   return int'(edit_tens);
        "time_left":   return int'(time_left);
        default:       return -1;
    endcase
endfunction

// Polls on falling edges where outputs have settled
task automatic wait_value(input string name, input int target, input int max_cycles);
    for (int n = 0; n < max_cycles; n++) begin
        @(negedge IN_CLK);
        if (output_value(name) == target) return;
    end
    abort_run($sformatf("%s did not reach %0d within %0d cycles", name, target, max_cycles));
endtask

task automatic wait_change(input string name, input int old, input int max_cycles,
                           output int now);
    for (int n = 0; n < max_cycles; n++) begin
        @(negedge IN_CLK);
        now = output_value(name);
        if (now != old) return;
    end
    abort_run($sformatf("%s stayed at %0d for %0d cycles", name, old, max_cycles));
endtask

task automatic wait_answer(output phase_t answer);
    for (int n = 0; n < answer_cycles; n++) begin
        @(negedge IN_CLK);
        if (phase inside {phase_high, phase_low, phase_win}) begin
            answer = phase;
            return;
        end
    end
    abort_run("a confirmed guess got no high, low or win answer");
endtask

// Hold and release last hold_samples sample ticks each
task automatic press_button(input button_code_t code, input int hold_samples = 12);
    @(posedge IN_CLK);
    #1 buttons[int'(code)] = 1'b1;
    repeat (hold_samples * sample_div) @(posedge IN_CLK);
    #1 buttons[int'(code)] = 1'b0;
    repeat (hold_samples * sample_div) @(posedge IN_CLK);
endtask

// Shortest path around the 0..9 ring
task automatic set_digit(input logic tens, input int target);
    int cur;
    int steps;
    @(negedge IN_CLK);
    if (edit_tens != tens) begin
        press_button(btn_toggle);
        wait_value("edit_tens", int'(tens), press_cycles);
    end
    cur   = tens ? int'(guess_tens) : int'(guess_units);
    steps = (target - cur + 10) % 10;   // Upward distance
    if (steps <= 5) begin
        repeat (steps) press_button(btn_up);
    end else begin
        repeat (10 - steps) press_button(btn_down);
    end
    if (tens) begin
        wait_value("guess_tens", target, press_cycles);
    end else begin
        wait_value("guess_units", target, press_cycles);
    end
endtask

task automatic enter_guess(input int value);
    set_digit(1'b1, value / 10);
    set_digit(1'b0, value % 10);
    press_button(btn_confirm);
endtask

task automatic start_game();
    press_button(btn_confirm);
    wait_value("phase", int'(phase_entry), load_cycles);
    wait_value("led", int'(led_entry), 2 * logic_div);   // One tick behind phase
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic test_reset_state();
    wait_value("led", int'(led_idle), 2 * logic_div);
    check_value("phase", int'(phase_idle), output_value("phase"));
    check_value("guess_tens", 0, output_value("guess_tens"));
    check_value("guess_units", 0, output_value("guess_units"));
    check_value("edit_tens", 1, output_value("edit_tens"));
    check_value("time_left", start_seconds, output_value("time_left"));
endtask

task automatic test_digit_editing();
    int now;
    int ups;
    start_game();
    press_button(btn_down);
    wait_change("guess_tens", 0, press_cycles, now);
    check_value("guess_tens", 9, now);                  // Wraps below zero
    press_button(btn_toggle);
    wait_value("edit_tens", 0, press_cycles);
    ups = ($random(seed) & 32'h7fff_ffff) % 13;        // Past 9 now and then
    for (int i = 1; i <= ups; i++) begin
        press_button(btn_up);
        wait_change("guess_units", (i - 1) % 10, press_cycles, now);
        check_value("guess_units", i % 10, now);
    end
    check_value("guess_units", ups % 10, output_value("guess_units"));
endtask

// Three presses closer together than two logic ticks
task automatic test_queued_burst();
    int start;
    start = output_value("guess_units");
    repeat (3) press_button(btn_up, 3);
    wait_value("guess_units", (start + 3) % 10, press_cycles);
    check_value("guess_tens", 9, output_value("guess_tens"));
endtask

task automatic test_countdown();
    int last;
    int now;
    last = output_value("time_left");
    repeat (2) begin
        wait_change("time_left", last, second_cycles, now);
        check_value("time_left", last - 1, now);       // One second down per change
        last = now;
    end
endtask

task automatic test_hints_and_win();
    int     lo;
    int     hi;
    int     mid;
    int     last;
    int     now;
    phase_t answer;
    lo = 0;
    hi = secret_limit - 1;
    for (int g = 0; g < 7; g++) begin
        mid = (lo + hi) / 2;
        enter_guess(mid);
        wait_answer(answer);
        if (answer == phase_win) begin
            check_value("led one-hot", 1, int'($onehot(led)));
            last = output_value("led");
            wait_change("led", last, led_div + 2 * logic_div, now);
            check_value("led", ((last << 1) | (last >> 15)) & 16'hffff, now);
            return;
        end
        if (answer == phase_high) begin
            check_value("led", int'(led_high), output_value("led"));
            hi = mid - 1;
        end else begin
            check_value("led", int'(led_low), output_value("led"));
            lo = mid + 1;
        end
        if (lo > hi) abort_run("hint answers leave no possible secret");
        wait_value("phase", int'(phase_entry), hint_cycles);
        check_value("guess_tens", 0, output_value("guess_tens"));
        check_value("guess_units", 0, output_value("guess_units"));
        check_value("edit_tens", 1, output_value("edit_tens"));
    end
    abort_run("secret not found within 7 guesses");
endtask

task automatic test_play_again();
    press_button(btn_confirm);
    wait_value("time_left", start_seconds, press_cycles);   // Idle reloads it
    check_value("phase", int'(phase_idle), output_value("phase"));
    check_value("led", int'(led_idle), output_value("led"));
endtask

task automatic test_timeout_loss();
    start_game();
    wait_value("time_left", 0, timeout_cycles);
    wait_value("phase", int'(phase_lose), 2 * logic_div);
    check_value("led", int'(led_lose), output_value("led"));
    press_button(btn_confirm);
    wait_value("phase", int'(phase_idle), press_cycles);
endtask

`endif

//--- tests/guess_number_tb.sv
`timescale 1ns/1ps

module guess_number_tb import guess_pkg::*; ();

    // ------------------------------------------------------------------
    // Timing limits, in clocks unless named otherwise
    // ------------------------------------------------------------------
    localparam int clk_period_ns  = 4;
    localparam int press_cycles   = 8 * logic_div;     // One press to its effect
    localparam int load_cycles    = 64 * logic_div;    // LFSR draw retries
    localparam int answer_cycles  = 4 * logic_div;
    localparam int second_cycles  = 2 * second_div;
    localparam int hint_cycles    = (hint_seconds + 2) * second_div;
    localparam int timeout_cycles = (start_seconds + 2) * second_div;
    // 130 game seconds plus 20 us of slack
    localparam longint watchdog_ns =
        longint'(130) * second_div * clk_period_ns + longint'(20_000);

    logic                 IN_CLK;
    logic                 ENABLE;
    logic [btn_count-1:0] buttons;      // Active high, one bit per button code
    phase_t               phase;
    logic [15:0]          led;
    digit_t               guess_tens;
    digit_t               guess_units;
    logic                 edit_tens;
    seconds_t             time_left;
    integer               seed;         // Picks the edit targets

    guess_number_top DUT (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .buttons     (buttons),
        .phase       (phase),
        .led         (led),
        .guess_tens  (guess_tens),
        .guess_units (guess_units),
        .edit_tens   (edit_tens),
        .time_left   (time_left)
    );

    // Queue rules watched from inside the press buffer
    bind press_queue guess_number_checker queue_checker (
        .IN_CLK      (IN_CLK),
        .ENABLE      (ENABLE),
        .pop         (pop),
        .queue_empty (queue_empty),
        .count       (count)
    );

    `include "guess_tb_tasks.svh"

    initial begin
        IN_CLK = 1'b0;
        forever #(clk_period_ns / 2) IN_CLK = ~IN_CLK;
    end

    initial begin
        #(watchdog_ns);
        abort_run("watchdog expired before the test sequence finished");
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        seed    = 77350;
        ENABLE  = 1'b0;                 // Reset held from time zero
        buttons = '0;
        repeat (2) @(posedge IN_CLK);
        #1 ENABLE = 1'b1;

        test_reset_state();
        test_digit_editing();
        test_queued_burst();
        test_countdown();               // Still in entry, nothing pressed
        test_hints_and_win();
        test_play_again();
        test_timeout_loss();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- guess_number.f
+incdir+include
design/guess_pkg.sv
design/tick_divider.sv
design/button_conditioner.sv
design/press_queue.sv
design/game_engine.sv
design/guess_number_top.sv
tests/guess_number_checker.sv
tests/guess_number_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= guess_number_tb
FILELIST  ?= guess_number.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
